// File: all.f
+incdir+include
hw/dac_pkg.sv
hw/credit_fifo.sv
hw/dac_prescaler.sv
hw/dac_scale_path.sv
sim/dac_scale_path_tb.sv

// File: Makefile
# Verilator build and run of the DAC scaling path testbench

VERILATOR ?= verilator
TOP       ?= dac_scale_path_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and the variables that can be overridden"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG TIMESCALE VFLAGS"

# the run itself may end with any status, the log search decides the result
test:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)
	-./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q -F '*** PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: include/tb_scale_model.svh
// LCG random source, per-lane scaling rule, expected-beat queue and clip count model
`ifndef TB_SCALE_MODEL_SVH
`define TB_SCALE_MODEL_SVH

`include "dac_defines.svh"

// state of the linear congruential generator, fixed seed for a repeatable run
int unsigned lcg_state = 32'd71579;

// beats the DUT has to deliver, oldest first
dac_pkg::beat_t exp_q[$];

// clipped samples seen so far, held at the counter maximum like the hardware counter
longint model_clip;

// next 16 random bits, taken from the upper half of the state
function automatic logic [15:0] rand16();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state[31:16];
endfunction

// true with the given chance in percent
function automatic bit chance(input int pct);
  return (int'(rand16()) % 100) < pct;
endfunction

// one lane before the clamp
// multiply, add half an output LSB at bit 15 and shift right arithmetically by 16
function automatic longint scale_lane(input longint sample, input longint k);
  longint p;
  p = sample * k + (longint'(1) <<< (`DAC_SCALE_FRAC - 1));
  return p >>> `DAC_SCALE_FRAC;
endfunction

// computes the expected beat for one sent beat and queues it
task automatic model_push(input dac_pkg::beat_t beat, input dac_pkg::scale_t k);
  localparam int W = `DAC_SAMPLE_WIDTH;
  dac_pkg::beat_t expected;
  longint r;
  longint smax;
  longint smin;
  int clips;
  smax = (longint'(1) <<< (W - 1)) - 1;
  smin = -(longint'(1) <<< (W - 1));
  clips = 0;
  for (int i = 0; i < `DAC_LANES; i++) begin
    r = scale_lane(longint'(dac_pkg::sample_t'(beat[i*W +: W])), longint'(k));
    // anything outside the signed sample range sits on its limit and is counted
    if (r > smax) begin
      r = smax;
      clips++;
    end else if (r < smin) begin
      r = smin;
      clips++;
    end
    expected[i*W +: W] = r[W-1:0];
  end
  model_clip = model_clip + clips;
  if (model_clip > (longint'(1) <<< `DAC_CLIP_WIDTH) - 1) begin
    model_clip = (longint'(1) <<< `DAC_CLIP_WIDTH) - 1;
  end
  exp_q.push_back(expected);
endtask

`endif

// File: sim/dac_scale_path_tb.sv
// dac_scale_path_tb module with clock, reset, random source and sink, checks and summary
`timescale 1ns/100ps
`include "dac_defines.svh"

module dac_scale_path_tb;

  localparam int W = `DAC_SAMPLE_WIDTH;
  // cycles a single phase may take before it counts as stuck
  localparam int PHASE_TIMEOUT = 5000;
  // idle cycles watched after a drain for beats that were never sent
  localparam int QUIET_CYCLES = 16;

  logic                 clk;
  logic                 reset;
  logic                 in_valid;
  dac_pkg::beat_t       in_data;
  logic                 in_credit;
  dac_pkg::scale_t      in_scale;
  logic                 out_valid;
  dac_pkg::beat_t       out_data;
  logic                 out_credit;
  dac_pkg::clip_count_t clip_count;

  // the source spends credits, the sink holds beats until it drains them
  int             src_credits;
  int             beats_sent;
  int             beats_received;
  int             credit_pulses;
  int             sample_mode;
  dac_pkg::beat_t sink_q[$];
  dac_pkg::clip_count_t clip_before;

  int data_errors;
  int flow_errors;
  int timeout_errors;
  bit timed_out;

  `include "tb_scale_model.svh"

  dac_scale_path u_dac_scale_path (
    .clk        (clk),
    .reset      (reset),
    .in_valid   (in_valid),
    .in_data    (in_data),
    .in_credit  (in_credit),
    .in_scale   (in_scale),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .out_credit (out_credit),
    .clip_count (clip_count)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic compare_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
    assert (actual === expected) else begin
      $display("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
      data_errors++;
    end
  endtask

  // mode 1 mixes the two extreme sample values into the lanes
  function automatic dac_pkg::beat_t random_beat();
    dac_pkg::beat_t beat;
    logic [15:0] r;
    for (int i = 0; i < `DAC_LANES; i++) begin
      r = rand16();
      if (sample_mode == 1 && r[1:0] == 2'd0) begin
        beat[i*W +: W] = {1'b0, {(W-1){1'b1}}};
      end else if (sample_mode == 1 && r[1:0] == 2'd1) begin
        beat[i*W +: W] = {1'b1, {(W-1){1'b0}}};
      end else begin
        beat[i*W +: W] = rand16();
      end
    end
    return beat;
  endfunction

  // one clock: outputs are read after the edge, the next inputs are driven right after
  task automatic run_cycle(input int send_pct, input int drain_pct, input int target);
    dac_pkg::beat_t beat;
    @(posedge clk);
    #0.5;
    if (in_credit) begin
      src_credits++;
      credit_pulses++;
    end
    assert (credit_pulses <= beats_sent) else begin
      $display("at %0t the path returned more in_credit pulses than beats were sent", $time);
      flow_errors++;
    end
    if (out_valid) begin
      assert (sink_q.size() < `DAC_OUT_DEPTH) else begin
        $display("at %0t out_valid arrived while the sink had no free slot", $time);
        flow_errors++;
      end
      beats_received++;
      sink_q.push_back(out_data);
      assert (exp_q.size() > 0) else begin
        $display("at %0t a beat arrived that was never sent", $time);
        data_errors++;
      end
      if (exp_q.size() > 0) begin
        compare_value("out_data", exp_q.pop_front(), out_data);
      end
    end
    assert (sink_q.size() <= `DAC_OUT_DEPTH) else begin
      $display("at %0t the sink holds more beats than it has slots", $time);
      flow_errors++;
    end
    // each drained beat hands one slot back as a single-cycle credit pulse
    out_credit = 1'b0;
    if (sink_q.size() > 0 && chance(drain_pct)) begin
      void'(sink_q.pop_front());
      out_credit = 1'b1;
    end
    in_valid = 1'b0;
    if (beats_sent < target && src_credits > 0 && chance(send_pct)) begin
      beat = random_beat();
      in_valid = 1'b1;
      in_data = beat;
      src_credits--;
      beats_sent++;
      model_push(beat, in_scale);
    end
  endtask

  // sends n beats and waits until every one of them has been received and drained
  task automatic run_phase(input int n, input int send_pct, input int drain_pct);
    int target;
    int cycles;
    target = beats_sent + n;
    cycles = 0;
    while (!timed_out && !(beats_sent == target && beats_received == beats_sent
                           && sink_q.size() == 0)) begin
      run_cycle(send_pct, drain_pct, target);
      cycles++;
      if (cycles >= PHASE_TIMEOUT) begin
        $display("timeout at %0t: the path did not drain, %0d beats sent, %0d received",
                 $time, beats_sent, beats_received);
        timeout_errors++;
        timed_out = 1'b1;
      end
    end
    if (!timed_out) begin
      // a quiet window after the drain shows any beat the path adds on its own
      repeat (QUIET_CYCLES) begin
        run_cycle(0, 100, target);
      end
      compare_value("beats_received", 64'(beats_sent), 64'(beats_received));
      // all input credits are back once the path is empty
      compare_value("src_credits", 64'(`DAC_IN_DEPTH), 64'(src_credits));
      compare_value("clip_count", 64'(model_clip), 64'(clip_count));
    end
  endtask

  initial begin
    reset = 1'b1;
    in_valid = 1'b0;
    in_data = '0;
    in_scale = dac_pkg::scale_t'(1 << `DAC_SCALE_FRAC);
    out_credit = 1'b0;
    src_credits = `DAC_IN_DEPTH;
    beats_sent = 0;
    beats_received = 0;
    credit_pulses = 0;
    sample_mode = 0;
    model_clip = 0;
    data_errors = 0;
    flow_errors = 0;
    timeout_errors = 0;
    timed_out = 1'b0;
    repeat (10) @(posedge clk);
    #0.5;
    reset = 1'b0;
    compare_value("out_valid", 64'(0), 64'(out_valid));
    compare_value("in_credit", 64'(0), 64'(in_credit));
    compare_value("clip_count", 64'(0), 64'(clip_count));
    // an idle source must leave the output quiet
    repeat (20) begin
      run_cycle(0, 100, beats_sent);
      compare_value("out_valid", 64'(0), 64'(out_valid));
    end
    // continuous source, immediate sink, odd rounds use a negative factor
    for (int k = 0; k < 4; k++) begin
      in_scale = dac_pkg::scale_t'({rand16(), rand16()});
      in_scale[`DAC_SCALE_WIDTH-1] = k[0];
      run_phase(40, 100, 100);
    end
    // random gaps on both sides put the credit loops under back-pressure
    for (int k = 0; k < 2; k++) begin
      in_scale = dac_pkg::scale_t'({rand16(), rand16()});
      run_phase(60, 55, 35);
    end
    // factors close to both range ends with extreme samples force clipping
    sample_mode = 1;
    in_scale = dac_pkg::scale_t'(-(1 << (`DAC_SCALE_WIDTH - 1)));
    run_phase(30, 80, 60);
    in_scale = dac_pkg::scale_t'(-(1 << (`DAC_SCALE_WIDTH - 1)) + 3);
    run_phase(30, 80, 60);
    in_scale = dac_pkg::scale_t'((1 << (`DAC_SCALE_WIDTH - 1)) - 1);
    run_phase(30, 80, 60);
    in_scale = dac_pkg::scale_t'((1 << (`DAC_SCALE_WIDTH - 1)) - 5);
    run_phase(30, 80, 60);
    // unity gain passes every sample through and clips nothing
    in_scale = dac_pkg::scale_t'(1 << `DAC_SCALE_FRAC);
    clip_before = clip_count;
    run_phase(30, 70, 70);
    compare_value("clip_count", 64'(clip_before), 64'(clip_count));
    $display("errors: data %0d, flow %0d, timeout %0d", data_errors, flow_errors,
             timeout_errors);
    if (data_errors + flow_errors + timeout_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: hw/dac_scale_path.sv
// dac_scale_path module, input buffer then prescaler then output buffer on credit links
`timescale 1ns/100ps
`include "dac_defines.svh"

module dac_scale_path (
  input  logic                 clk,
  input  logic                 reset,
  // source side, the source starts with DAC_IN_DEPTH credits
  input  logic                 in_valid,
  input  dac_pkg::beat_t       in_data,
  output logic                 in_credit,
  // static configuration
  input  dac_pkg::scale_t      in_scale,
  // sink side, the sink is assumed to offer DAC_OUT_DEPTH slots after reset
  output logic                 out_valid,
  output dac_pkg::beat_t       out_data,
  input  logic                 out_credit,
  output dac_pkg::clip_count_t clip_count
);

  // link from the input buffer into the prescaler
  logic           pre_in_valid;
  dac_pkg::beat_t pre_in_data;
  logic           pre_in_credit;

  // link from the prescaler into the output buffer
  logic           pre_out_valid;
  dac_pkg::beat_t pre_out_data;
  logic           pre_out_credit;

  // the input buffer may launch as many beats as the output buffer can hold
  credit_fifo #(
    .DEPTH        (`DAC_IN_DEPTH),
    .INIT_CREDITS (`DAC_OUT_DEPTH)
  ) u_in_fifo (
    .clk       (clk),
    .reset     (reset),
    .wr_valid  (in_valid),
    .wr_data   (in_data),
    .wr_credit (in_credit),
    .rd_valid  (pre_in_valid),
    .rd_data   (pre_in_data),
    .rd_credit (pre_in_credit)
  );

  dac_prescaler u_prescaler (
    .clk        (clk),
    .reset      (reset),
    .in_valid   (pre_in_valid),
    .in_data    (pre_in_data),
    .in_credit  (pre_in_credit),
    .scale      (in_scale),
    .out_valid  (pre_out_valid),
    .out_data   (pre_out_data),
    .out_credit (pre_out_credit),
    .clip_count (clip_count)
  );

  credit_fifo #(
    .DEPTH        (`DAC_OUT_DEPTH),
    .INIT_CREDITS (`DAC_OUT_DEPTH)
  ) u_out_fifo (
    .clk       (clk),
    .reset     (reset),
    .wr_valid  (pre_out_valid),
    .wr_data   (pre_out_data),
    .wr_credit (pre_out_credit),
    .rd_valid  (out_valid),
    .rd_data   (out_data),
    .rd_credit (out_credit)
  );

endmodule

// File: hw/dac_prescaler.sv
// dac_prescaler module, a two-stage lane multiply, round and saturate pipeline with clip count
`timescale 1ns/100ps
`include "dac_defines.svh"

module dac_prescaler (
  input  logic                 clk,
  input  logic                 reset,
  // beats from the input buffer, accepted every cycle without a stall
  input  logic                 in_valid,
  input  dac_pkg::beat_t       in_data,
  output logic                 in_credit,
  // static scale factor, only changed while the path is empty
  input  dac_pkg::scale_t      scale,
  // scaled beats toward the output buffer
  output logic                 out_valid,
  output dac_pkg::beat_t       out_data,
  input  logic                 out_credit,
  output dac_pkg::clip_count_t clip_count
);

  localparam int SW = `DAC_SAMPLE_WIDTH;

  // half an output LSB, added before the shift so that rounding goes half up
  localparam dac_pkg::product_t ROUND_HALF = dac_pkg::product_t'(2 ** (`DAC_SCALE_FRAC - 1));

  // clamp limits of the signed sample range at product width
  localparam dac_pkg::product_t SAMPLE_MAX = dac_pkg::product_t'(2 ** (SW - 1) - 1);
  localparam dac_pkg::product_t SAMPLE_MIN = dac_pkg::product_t'(-(2 ** (SW - 1)));

  // enough bits to count every lane of one beat as clipped
  localparam int LANE_CNT_W = $clog2(`DAC_LANES + 1);
  // one extra bit to detect that the clip counter would wrap
  localparam int SUM_W = `DAC_CLIP_WIDTH + 1;

  dac_pkg::scale_t   scale_q;
  logic              valid_q;
  dac_pkg::product_t prod_q [`DAC_LANES];

  dac_pkg::product_t     rounded [`DAC_LANES];
  logic [`DAC_LANES-1:0] clipped;
  dac_pkg::beat_t        sat_data;
  logic [LANE_CNT_W-1:0] clip_lanes;
  logic [SUM_W-1:0]      clip_sum;

  // the scale factor is sampled every cycle
  // a change while beats are in flight gives undefined results for those beats
  always_ff @(posedge clk) begin
    scale_q <= scale;
  end

  // first stage keeps the full product of every lane
  // both operands are signed so the product is sign extended to product width
  always_ff @(posedge clk) begin
    if (in_valid) begin
      for (int i = 0; i < `DAC_LANES; i++) begin
        prod_q[i] <= dac_pkg::sample_t'(in_data[i*SW +: SW]) * scale_q;
      end
    end
  end

  // second stage works on the registered products
  // the sample fraction bits cancel so only the scale fraction bits are shifted out
  always_comb begin
    sat_data = '0;
    clipped  = '0;
    for (int i = 0; i < `DAC_LANES; i++) begin
      rounded[i] = (prod_q[i] + ROUND_HALF) >>> `DAC_SCALE_FRAC;
      if (rounded[i] > SAMPLE_MAX) begin
        sat_data[i*SW +: SW] = SW'(SAMPLE_MAX);
        clipped[i]           = 1'b1;
      end else if (rounded[i] < SAMPLE_MIN) begin
        sat_data[i*SW +: SW] = SW'(SAMPLE_MIN);
        clipped[i]           = 1'b1;
      end else begin
        sat_data[i*SW +: SW] = rounded[i][SW-1:0];
      end
    end
  end

  // count how many lanes of this beat were limited
  always_comb begin
    clip_lanes = '0;
    for (int i = 0; i < `DAC_LANES; i++) begin
      clip_lanes = clip_lanes + LANE_CNT_W'(clipped[i]);
    end
  end

  assign clip_sum = {1'b0, clip_count} + SUM_W'(clip_lanes);

  always_ff @(posedge clk) begin
    if (valid_q) begin
      out_data <= sat_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q    <= 1'b0;
      out_valid  <= 1'b0;
      in_credit  <= 1'b0;
      clip_count <= '0;
    end else begin
      valid_q   <= in_valid;
      out_valid <= valid_q;
      // every accepted beat already owns an output buffer slot
      // so the downstream credits are simply passed back one cycle later
      in_credit <= out_credit;
      // the count moves together with the beat it belongs to and holds at its maximum
      if (valid_q) begin
        if (clip_sum[SUM_W-1]) begin
          clip_count <= '1;
        end else begin
          clip_count <= clip_sum[SUM_W-2:0];
        end
      end
    end
  end

endmodule

// File: hw/credit_fifo.sv
// credit_fifo module, a credit-governed beat buffer that sends onward under its own credits
`timescale 1ns/100ps
`include "dac_defines.svh"

module credit_fifo #(
  parameter int DEPTH        = `DAC_IN_DEPTH,
  parameter int INIT_CREDITS = `DAC_OUT_DEPTH
) (
  input  logic           clk,
  input  logic           reset,
  // write side, the upstream sender only launches a beat when it holds a credit
  input  logic           wr_valid,
  input  dac_pkg::beat_t wr_data,
  output logic           wr_credit,
  // read side, launched when this buffer holds a credit for the receiver
  output logic           rd_valid,
  output dac_pkg::beat_t rd_data,
  input  logic           rd_credit
);

  localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  // beat storage in a circular buffer
  dac_pkg::beat_t mem [DEPTH];

  logic [PTR_WIDTH-1:0]  wr_ptr;
  logic [PTR_WIDTH-1:0]  rd_ptr;
  // number of beats currently held
  dac_pkg::credit_count_t fill;
  // credits held toward the downstream receiver
  dac_pkg::credit_count_t credits;
  logic                   pop;

  // pointers wrap at DEPTH so that depths other than a power of two still work
  function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
    if (ptr == PTR_WIDTH'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // a beat leaves whenever something is stored and the receiver has room for it
  assign pop = (fill != '0) && (credits != '0);

  // incoming beats are written without a room check
  // the sender's credit count already guarantees that a slot is free
  always_ff @(posedge clk) begin
    if (wr_valid) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // the output word is registered so that a beat written at one edge
  // can be sent at the next edge at the earliest
  always_ff @(posedge clk) begin
    if (pop) begin
      rd_data <= mem[rd_ptr];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      fill      <= '0;
      credits   <= dac_pkg::credit_count_t'(INIT_CREDITS);
      rd_valid  <= 1'b0;
      wr_credit <= 1'b0;
    end else begin
      if (wr_valid) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      // write and pop in the same cycle leave the occupancy unchanged
      fill <= fill + dac_pkg::credit_count_t'(wr_valid) - dac_pkg::credit_count_t'(pop);
      // a returned credit and a send in the same cycle also cancel out
      credits <= credits + dac_pkg::credit_count_t'(rd_credit)
                 - dac_pkg::credit_count_t'(pop);
      rd_valid <= pop;
      // the freed slot is handed back upstream in the cycle after the pop
      wr_credit <= pop;
    end
  end

endmodule

// File: hw/dac_pkg.sv
// shared typedefs for samples, beats, scale factor, products and counters
`include "dac_defines.svh"

package dac_pkg;

  // one signed sample in the DAC number format
  typedef logic signed [`DAC_SAMPLE_WIDTH-1:0] sample_t;

  // all lanes of one beat packed together with lane 0 in the low bits
  typedef logic [`DAC_LANES*`DAC_SAMPLE_WIDTH-1:0] beat_t;

  // signed scale factor applied to every lane
  typedef logic signed [`DAC_SCALE_WIDTH-1:0] scale_t;

  // full precision product of one sample and the scale factor
  typedef logic signed [`DAC_SAMPLE_WIDTH+`DAC_SCALE_WIDTH-1:0] product_t;

  // number of samples that hit the clamp limits, stops at all ones
  typedef logic [`DAC_CLIP_WIDTH-1:0] clip_count_t;

  // sized so that the deeper of the two buffers still fits, including the full value
  typedef logic [$clog2((`DAC_IN_DEPTH > `DAC_OUT_DEPTH ? `DAC_IN_DEPTH : `DAC_OUT_DEPTH) + 1)-1:0]
    credit_count_t;

endpackage

// File: include/dac_defines.svh
// sample, lane, scale, clip counter and buffer depth macros for the DAC scaling path
`ifndef DAC_DEFINES_SVH
`define DAC_DEFINES_SVH

// width of one signed DAC sample
`define DAC_SAMPLE_WIDTH 16

// number of parallel samples carried by one beat
`define DAC_LANES 4

// signed scale factor width and its fraction bits, giving a range of [-2, 2)
`define DAC_SCALE_WIDTH 18
`define DAC_SCALE_FRAC 16

// input buffer depth, which is also the credit count the external source starts with
`define DAC_IN_DEPTH 8

// output buffer depth, which sets the credits the input buffer starts with
`define DAC_OUT_DEPTH 8

// width of the saturating counter of clipped samples
`define DAC_CLIP_WIDTH 16

`endif
